// ==== hw/foc_config.svh ====
`ifndef FOC_CONFIG_SVH
`define FOC_CONFIG_SVH

// sample word width and fraction bits
`define FOC_DW    16
`define FOC_QBITS 15

// pwm carrier counter width
`define FOC_CW    12

// 1/sqrt(3) scaled by 2^15
`define FOC_INV_SQRT3  18919

// sqrt(3)/2 scaled by 2^15
`define FOC_SQRT3_HALF 28378

`endif

// ==== hw/foc_pkg.sv ====
`include "foc_config.svh"

package foc_pkg;

  typedef logic signed [`FOC_DW-1:0] q15_t;

  // symmetric saturation limit, -32768 is never produced
  localparam int q15_max = (1 << (`FOC_DW - 1)) - 1;

  typedef struct packed {
    q15_t ia;
    q15_t ib;
    q15_t sin_theta;
    q15_t cos_theta;
    q15_t iq_target;
  } sample_t;

  // axis 0 = d, 1 = q; kind 0 = kp, 1 = ki
  typedef struct packed {
    logic en;
    logic axis;
    logic kind;
    q15_t value;
  } coef_wr_t;

  typedef struct packed {
    q15_t d;
    q15_t q;
  } dq_t;

  typedef struct packed {
    dq_t meas;
    dq_t cmd;
  } telemetry_t;

  typedef struct packed {
    logic [`FOC_CW-1:0] a;
    logic [`FOC_CW-1:0] b;
    logic [`FOC_CW-1:0] c;
  } phase_duty_t;

  // clamp a wide signed value into one word
  function automatic q15_t q15_sat(input logic signed [2*`FOC_DW-1:0] x);
    if (x > q15_max) begin
      return q15_t'(q15_max);
    end
    if (x < -q15_max) begin
      return q15_t'(-q15_max);
    end
    return q15_t'(x);
  endfunction

  function automatic q15_t q15_mul_sat(input q15_t a, input q15_t b);
    logic signed [2*`FOC_DW-1:0] prod;
    prod = a * b;
    return q15_sat(prod >>> `FOC_QBITS);
  endfunction

endpackage

// ==== hw/foc_sequencer.sv ====
`timescale 1ns/1ns

module foc_sequencer (
  input  logic clk,
  input  logic arst_n,
  input  logic sample_req,
  output logic sample_ack,
  output logic xform_en,
  output logic reg_en,
  output logic mod_en,
  output logic sample_load
);

  // one state per pipeline step, one sample in flight
  typedef enum logic [2:0] {
    st_idle,
    st_transform,
    st_regulate,
    st_modulate,
    st_hold
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        // ack is low here, so req high starts a new sample
        if (sample_req) begin
          state_next = st_transform;
        end
      end
      st_transform: begin
        state_next = st_regulate;
      end
      st_regulate: begin
        state_next = st_modulate;
      end
      st_modulate: begin
        state_next = st_hold;
      end
      st_hold: begin
        // ack stays up until the requester drops req
        if (!sample_req) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // latch edge is cycle 0, strobes follow in cycles 1..3
  assign sample_load = (state == st_idle) && sample_req;
  assign xform_en    = (state == st_transform);
  assign reg_en      = (state == st_regulate);
  assign mod_en      = (state == st_modulate);

  // ack from cycle 4, falls one cycle after req is seen low
  assign sample_ack  = (state == st_hold);

endmodule

// ==== hw/pwm_carrier.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module pwm_carrier (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [`FOC_CW-1:0] period_top,
  output logic [`FOC_CW-1:0] count,
  output logic              wrap
);

  // top in use for the running period
  logic [`FOC_CW-1:0] top_q;

  // last count of a period, count returns to 0 on the next edge
  assign wrap = (count == top_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
      top_q <= '0;
    end else if (wrap) begin
      count <= '0;
      // new top only between periods
      top_q <= period_top;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== hw/current_transform.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module current_transform (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             sample_load,
  input  foc_pkg::sample_t sample,
  input  logic             xform_en,
  output foc_pkg::dq_t     meas,
  output foc_pkg::dq_t     sin_cos,
  output foc_pkg::q15_t    iq_target
);

  import foc_pkg::*;

  localparam q15_t inv_sqrt3 = q15_t'(`FOC_INV_SQRT3);

  sample_t                     smp_q;
  logic signed [2*`FOC_DW-1:0] ab_sum;
  logic signed [2*`FOC_DW-1:0] d_sum;
  logic signed [2*`FOC_DW-1:0] q_sum;
  q15_t                        alpha;
  q15_t                        beta;
  q15_t                        d_next;
  q15_t                        q_next;

  always_ff @(posedge clk) begin
    if (sample_load) begin
      smp_q <= sample;
    end
  end

  always_comb begin
    // clarke, two-current form
    alpha  = smp_q.ia;
    ab_sum = smp_q.ia + smp_q.ib + smp_q.ib;
    beta   = q15_mul_sat(q15_sat(ab_sum), inv_sqrt3);

    // park onto the rotor frame
    d_sum  = q15_mul_sat(alpha, smp_q.cos_theta) + q15_mul_sat(beta, smp_q.sin_theta);
    q_sum  = q15_mul_sat(beta, smp_q.cos_theta) - q15_mul_sat(alpha, smp_q.sin_theta);
    d_next = q15_sat(d_sum);
    q_next = q15_sat(q_sum);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meas <= '0;
    end else if (xform_en) begin
      meas.d <= d_next;
      meas.q <= q_next;
    end
  end

  // angle is reused by the inverse park later on
  assign sin_cos   = '{d: smp_q.sin_theta, q: smp_q.cos_theta};
  assign iq_target = smp_q.iq_target;

endmodule

// ==== hw/pi_regulator.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module pi_regulator #(
  parameter bit axis_sel = 1'b0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  foc_pkg::coef_wr_t coef_wr,
  input  logic              reg_en,
  input  foc_pkg::q15_t     setpoint,
  input  foc_pkg::q15_t     feedback,
  output foc_pkg::q15_t     out_cmd
);

  import foc_pkg::*;

  q15_t                        kp;
  q15_t                        ki;
  q15_t                        integ;
  q15_t                        err;
  q15_t                        integ_next;
  q15_t                        out_next;
  logic signed [2*`FOC_DW-1:0] err_wide;
  logic signed [2*`FOC_DW-1:0] integ_wide;
  logic signed [2*`FOC_DW-1:0] out_wide;
  logic                        gain_hit;

  // gain write addressed to this axis
  assign gain_hit = coef_wr.en && (coef_wr.axis == axis_sel);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      kp <= '0;
      ki <= '0;
    end else if (gain_hit) begin
      if (coef_wr.kind) begin
        ki <= coef_wr.value;
      end else begin
        kp <= coef_wr.value;
      end
    end
  end

  always_comb begin
    err_wide   = setpoint - feedback;
    err        = q15_sat(err_wide);
    // integrator clamps, no windup past full scale
    integ_wide = integ + q15_mul_sat(ki, err);
    integ_next = q15_sat(integ_wide);
    // output uses the freshly updated integral
    out_wide   = q15_mul_sat(kp, err) + integ_next;
    out_next   = q15_sat(out_wide);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      integ   <= '0;
      out_cmd <= '0;
    end else if (reg_en) begin
      integ   <= integ_next;
      out_cmd <= out_next;
    end
  end

endmodule

// ==== hw/voltage_modulator.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module voltage_modulator (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               mod_en,
  input  foc_pkg::dq_t       vcmd,
  input  foc_pkg::dq_t       sin_cos,
  input  logic [`FOC_CW-1:0] period_top,
  input  logic [`FOC_CW-1:0] count,
  input  logic               wrap,
  output logic               pwm_a,
  output logic               pwm_b,
  output logic               pwm_c
);

  import foc_pkg::*;

  localparam q15_t sqrt3_half = q15_t'(`FOC_SQRT3_HALF);

  // extra bit so a duty of period_top+1 holds a phase high all period
  typedef logic [`FOC_CW:0] duty_t;

  duty_t                       span;
  duty_t                       pend_a;
  duty_t                       pend_b;
  duty_t                       pend_c;
  duty_t                       act_a;
  duty_t                       act_b;
  duty_t                       act_c;
  logic signed [2*`FOC_DW-1:0] alpha_wide;
  logic signed [2*`FOC_DW-1:0] beta_wide;
  logic signed [2*`FOC_DW-1:0] b_wide;
  logic signed [2*`FOC_DW-1:0] c_wide;
  q15_t                        valpha;
  q15_t                        vbeta;
  q15_t                        half_alpha;
  q15_t                        beta_term;
  q15_t                        vb;
  q15_t                        vc;

  // mid-scale plus v*full/65536, floored, clamped to 0..full
  function automatic duty_t scale_duty(input q15_t v, input duty_t full);
    logic signed [2*`FOC_DW-1:0] scaled;
    logic signed [2*`FOC_DW-1:0] duty;
    scaled = (v * $signed({1'b0, full})) >>> `FOC_DW;
    duty   = $signed({1'b0, full >> 1}) + scaled;
    if (duty < 0) begin
      return '0;
    end
    if (duty > $signed({1'b0, full})) begin
      return full;
    end
    return duty_t'(duty);
  endfunction

  assign span = {1'b0, period_top} + 1'b1;

  always_comb begin
    // inverse park, sin in d and cos in q
    alpha_wide = q15_mul_sat(vcmd.d, sin_cos.q) - q15_mul_sat(vcmd.q, sin_cos.d);
    beta_wide  = q15_mul_sat(vcmd.d, sin_cos.d) + q15_mul_sat(vcmd.q, sin_cos.q);
    valpha     = q15_sat(alpha_wide);
    vbeta      = q15_sat(beta_wide);
    // inverse clarke, phase a is alpha itself
    half_alpha = valpha >>> 1;
    beta_term  = q15_mul_sat(vbeta, sqrt3_half);
    b_wide     = beta_term - half_alpha;
    c_wide     = -half_alpha - beta_term;
    vb         = q15_sat(b_wide);
    vc         = q15_sat(c_wide);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_a <= '0;
      pend_b <= '0;
      pend_c <= '0;
      act_a  <= '0;
      act_b  <= '0;
      act_c  <= '0;
    end else begin
      if (mod_en) begin
        pend_a <= scale_duty(valpha, span);
        pend_b <= scale_duty(vb, span);
        pend_c <= scale_duty(vc, span);
      end
      // shadow copy between carrier periods
      if (wrap) begin
        act_a <= pend_a;
        act_b <= pend_b;
        act_c <= pend_c;
      end
    end
  end

  // edge aligned, high from count 0 up to duty-1
  assign pwm_a = {1'b0, count} < act_a;
  assign pwm_b = {1'b0, count} < act_b;
  assign pwm_c = {1'b0, count} < act_c;

endmodule

// ==== hw/foc_top.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module foc_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                sample_req,
  input  foc_pkg::sample_t    sample,
  output logic                sample_ack,
  input  foc_pkg::coef_wr_t   coef_wr,
  input  logic [`FOC_CW-1:0]  period_top,
  output foc_pkg::telemetry_t telemetry,
  output logic                pwm_a,
  output logic                pwm_b,
  output logic                pwm_c
);

  import foc_pkg::*;

  logic               sample_load;
  logic               xform_en;
  logic               reg_en;
  logic               mod_en;
  logic [`FOC_CW-1:0] count;
  logic               wrap;
  dq_t                meas;
  dq_t                sin_cos;
  dq_t                vcmd;
  q15_t               iq_target;
  q15_t               vd_cmd;
  q15_t               vq_cmd;

  foc_sequencer u_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .sample_req  (sample_req),
    .sample_ack  (sample_ack),
    .xform_en    (xform_en),
    .reg_en      (reg_en),
    .mod_en      (mod_en),
    .sample_load (sample_load)
  );

  pwm_carrier u_carrier (
    .clk        (clk),
    .arst_n     (arst_n),
    .period_top (period_top),
    .count      (count),
    .wrap       (wrap)
  );

  current_transform u_xform (
    .clk         (clk),
    .arst_n      (arst_n),
    .sample_load (sample_load),
    .sample      (sample),
    .xform_en    (xform_en),
    .meas        (meas),
    .sin_cos     (sin_cos),
    .iq_target   (iq_target)
  );

  // flux axis held at zero current
  pi_regulator #(.axis_sel(1'b0)) pi_d (
    .clk      (clk),
    .arst_n   (arst_n),
    .coef_wr  (coef_wr),
    .reg_en   (reg_en),
    .setpoint ('0),
    .feedback (meas.d),
    .out_cmd  (vd_cmd)
  );

  pi_regulator #(.axis_sel(1'b1)) pi_q (
    .clk      (clk),
    .arst_n   (arst_n),
    .coef_wr  (coef_wr),
    .reg_en   (reg_en),
    .setpoint (iq_target),
    .feedback (meas.q),
    .out_cmd  (vq_cmd)
  );

  voltage_modulator u_mod (
    .clk        (clk),
    .arst_n     (arst_n),
    .mod_en     (mod_en),
    .vcmd       (vcmd),
    .sin_cos    (sin_cos),
    .period_top (period_top),
    .count      (count),
    .wrap       (wrap),
    .pwm_a      (pwm_a),
    .pwm_b      (pwm_b),
    .pwm_c      (pwm_c)
  );

  assign vcmd      = '{d: vd_cmd, q: vq_cmd};
  // both halves already registered, stable while ack is high
  assign telemetry = '{meas: meas, cmd: vcmd};

endmodule

// ==== testbench/foc_tb_model.svh ====
`ifndef FOC_TB_MODEL_SVH
`define FOC_TB_MODEL_SVH

  // Q15 sine at 30 degree steps, cosine reads three entries ahead
  localparam int sin_tab [0:11] = '{0, 16384, 28378, 32767, 28378, 16384,
                                    0, -16384, -28378, -32767, -28378, -16384};

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper half of the next state, shifted down to limit the range
  function automatic q15_t rand_word(inout logic [31:0] state, input int shift);
    state = lcg_next(state);
    return $signed(state[31:16]) >>> shift;
  endfunction

  function automatic q15_t sat_word(input int x);
    if (x > 32767) begin
      return 16'sd32767;
    end
    if (x < -32767) begin
      return -16'sd32767;
    end
    return q15_t'(x);
  endfunction

  function automatic q15_t mul_q15(input q15_t a, input q15_t b);
    return sat_word((int'(a) * int'(b)) >>> `FOC_QBITS);
  endfunction

  function automatic sample_t make_sample(input q15_t ia, input q15_t ib, input int angle,
                                          input q15_t iq_target);
    sample_t s;
    s.ia        = ia;
    s.ib        = ib;
    s.sin_theta = q15_t'(sin_tab[angle % 12]);
    s.cos_theta = q15_t'(sin_tab[(angle + 3) % 12]);
    s.iq_target = iq_target;
    return s;
  endfunction

  // clarke from two currents, then park onto the rotor angle
  function automatic dq_t clarke_park(input sample_t s);
    q15_t beta;
    dq_t  r;
    beta = mul_q15(sat_word(int'(s.ia) + 2 * int'(s.ib)), q15_t'(`FOC_INV_SQRT3));
    r.d  = sat_word(int'(mul_q15(s.ia, s.cos_theta)) + int'(mul_q15(beta, s.sin_theta)));
    r.q  = sat_word(int'(mul_q15(beta, s.cos_theta)) - int'(mul_q15(s.ia, s.sin_theta)));
    return r;
  endfunction

  // integ is the model's own integrator for that axis
  function automatic q15_t pi_step(input q15_t setpoint, input q15_t feedback, input q15_t kp,
                                   input q15_t ki, inout q15_t integ);
    q15_t err;
    err   = sat_word(int'(setpoint) - int'(feedback));
    integ = sat_word(int'(integ) + int'(mul_q15(ki, err)));
    return sat_word(int'(mul_q15(kp, err)) + int'(integ));
  endfunction

  function automatic logic [`FOC_CW-1:0] one_duty(input q15_t v, input int span);
    int d;
    d = span / 2 + ((int'(v) * span) >>> 16);
    if (d < 0) begin
      d = 0;
    end
    if (d > span) begin
      d = span;
    end
    return d[`FOC_CW-1:0];
  endfunction

  // inverse park and inverse clarke, then duty per phase
  function automatic phase_duty_t duty_from_vcmd(input dq_t v, input q15_t sin_t,
                                                 input q15_t cos_t, input int top);
    q15_t        valpha;
    q15_t        vbeta;
    q15_t        half;
    q15_t        bterm;
    phase_duty_t r;
    valpha = sat_word(int'(mul_q15(v.d, cos_t)) - int'(mul_q15(v.q, sin_t)));
    vbeta  = sat_word(int'(mul_q15(v.d, sin_t)) + int'(mul_q15(v.q, cos_t)));
    half   = valpha >>> 1;
    bterm  = mul_q15(vbeta, q15_t'(`FOC_SQRT3_HALF));
    r.a    = one_duty(valpha, top + 1);
    r.b    = one_duty(sat_word(int'(bterm) - int'(half)), top + 1);
    r.c    = one_duty(sat_word(-int'(half) - int'(bterm)), top + 1);
    return r;
  endfunction

`endif

// ==== testbench/foc_tb.sv ====
`timescale 1ns/1ns
`include "foc_config.svh"

module foc_tb;

  import foc_pkg::*;

  `include "foc_tb_model.svh"

  localparam int top_a       = 99;
  localparam int top_b       = 149;
  localparam int num_random  = 6;
  localparam int num_ramp    = 8;
  localparam int num_sat     = 4;
  localparam int num_samples = num_random + num_ramp + num_sat + 3;
  // handshake plus three carrier periods per sample, 4 ns clock
  localparam int watchdog_ns = num_samples * (8 + 3 * (top_b + 1)) * 4;

  logic               clk;
  logic               arst_n;
  logic               sample_req;
  logic               sample_ack;
  sample_t            sample;
  coef_wr_t           coef_wr;
  logic [`FOC_CW-1:0] period_top;
  telemetry_t         telemetry;
  logic               pwm_a;
  logic               pwm_b;
  logic               pwm_c;

  // model state, gains follow the coefficient writes
  q15_t        kp_d;
  q15_t        ki_d;
  q15_t        kp_q;
  q15_t        ki_q;
  q15_t        integ_d;
  q15_t        integ_q;
  phase_duty_t exp_duty;
  logic [31:0] seed;
  int          ack_count;

  foc_top uut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2;
      clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_dq(input dq_t got, input dq_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s is d=%0d q=%0d, expected d=%0d q=%0d",
                          $time, what, got.d, got.q, exp.d, exp.q));
    end
  endtask

  task automatic check_duty(input phase_duty_t got, input phase_duty_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s is a=%0d b=%0d c=%0d, expected a=%0d b=%0d c=%0d",
                          $time, what, got.a, got.b, got.c, exp.a, exp.b, exp.c));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  function automatic sample_t random_sample();
    q15_t ia;
    q15_t ib;
    q15_t iq;
    ia   = rand_word(seed, 2);
    ib   = rand_word(seed, 2);
    iq   = rand_word(seed, 1);
    seed = lcg_next(seed);
    return make_sample(ia, ib, int'(seed[31:24]) % 12, iq);
  endfunction

  // raise req and wait for ack, returns on the negedge that sees it
  task automatic send_sample(input sample_t s);
    int waited = 0;
    @(posedge clk);
    #1;
    sample     = s;
    sample_req = 1'b1;
    @(negedge clk);
    while (!sample_ack) begin
      waited++;
      if (waited > 16) begin
        abort_run("the core did not acknowledge a sample within 16 cycles");
      end
      @(negedge clk);
    end
  endtask

  task automatic release_req();
    @(posedge clk);
    #1;
    sample_req = 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit(sample_ack, 1'b0, "sample_ack one cycle after req low");
  endtask

  task automatic write_gain(input logic axis, input logic kind, input q15_t value);
    @(posedge clk);
    #1;
    coef_wr = '{en: 1'b1, axis: axis, kind: kind, value: value};
    @(posedge clk);
    #1;
    coef_wr = '0;
  endtask

  // cycles up to and including the next wrap
  task automatic period_length(output int len);
    len = 0;
    do begin
      @(negedge clk);
      len++;
    end while (!uut.wrap);
  endtask

  // skip two wraps so the new duties are active, then count one period
  task automatic measure_duty(input int span, output phase_duty_t got);
    int len;
    period_length(len);
    period_length(len);
    got = '0;
    repeat (span) begin
      @(negedge clk);
      got.a += pwm_a;
      got.b += pwm_b;
      got.c += pwm_c;
    end
  endtask

  initial begin : compare_on_ack
    logic ack_prev;
    dq_t  meas_exp;
    dq_t  cmd_exp;
    ack_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (sample_ack && !ack_prev) begin
        meas_exp  = clarke_park(sample);
        cmd_exp.d = pi_step(16'sd0, meas_exp.d, kp_d, ki_d, integ_d);
        cmd_exp.q = pi_step(sample.iq_target, meas_exp.q, kp_q, ki_q, integ_q);
        exp_duty  = duty_from_vcmd(cmd_exp, sample.sin_theta, sample.cos_theta, period_top);
        check_dq(telemetry.meas, meas_exp, "telemetry.meas");
        check_dq(telemetry.cmd, cmd_exp, "telemetry.cmd");
        ack_count++;
      end
      ack_prev = sample_ack;
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run($sformatf("timeout, the run did not finish within %0d ns", watchdog_ns));
  end

  initial begin
    sample_t    s;
    telemetry_t held;
    phase_duty_t duty;
    int         len;
    arst_n     = 1'b0;
    sample_req = 1'b0;
    sample     = '0;
    coef_wr    = '0;
    period_top = top_a[`FOC_CW-1:0];
    kp_d       = '0;
    ki_d       = '0;
    kp_q       = '0;
    ki_q       = '0;
    integ_d    = '0;
    integ_q    = '0;
    exp_duty   = '0;
    seed       = 32'h1bcc_5cce;
    ack_count  = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    @(negedge clk);
    check_bit(sample_ack, 1'b0, "sample_ack after reset");
    check_bit(pwm_a | pwm_b | pwm_c, 1'b0, "pwm outputs after reset");
    check_dq(telemetry.meas, '0, "telemetry.meas after reset");
    check_dq(telemetry.cmd, '0, "telemetry.cmd after reset");

    // transform only, gains still zero
    repeat (num_random) begin
      s = random_sample();
      send_sample(s);
      release_req();
    end

    write_gain(1'b0, 1'b0, 16'sd4096);
    write_gain(1'b0, 1'b1, 16'sd512);
    write_gain(1'b1, 1'b0, 16'sd4096);
    write_gain(1'b1, 1'b1, 16'sd512);
    kp_d = 16'sd4096;
    ki_d = 16'sd512;
    kp_q = 16'sd4096;
    ki_q = 16'sd512;

    // same sample again and again, integrators ramp
    s = make_sample(16'sd1000, 16'sd0, 0, 16'sd4000);
    repeat (num_ramp) begin
      send_sample(s);
      release_req();
    end

    s = random_sample();
    send_sample(s);
    release_req();
    measure_duty(top_a + 1, duty);
    check_duty(duty, exp_duty, "pwm duty with top_a");

    // new top is latched at a wrap, so the running period keeps the old one
    period_length(len);
    @(posedge clk);
    #1;
    period_top = top_b[`FOC_CW-1:0];
    period_length(len);
    check_bit(len == top_a + 1, 1'b1, $sformatf("period of %0d cycles after top change", len));
    period_length(len);
    check_bit(len == top_b + 1, 1'b1, $sformatf("period of %0d cycles with new top", len));
    s = random_sample();
    send_sample(s);
    release_req();
    measure_duty(top_b + 1, duty);
    check_duty(duty, exp_duty, "pwm duty with top_b");

    // req held high after ack
    s = random_sample();
    send_sample(s);
    held = telemetry;
    repeat (20) begin
      @(negedge clk);
      check_bit(sample_ack, 1'b1, "sample_ack while req held");
      check_dq(telemetry.meas, held.meas, "telemetry.meas while req held");
      check_dq(telemetry.cmd, held.cmd, "telemetry.cmd while req held");
    end
    release_req();

    // full torque demand at zero current
    write_gain(1'b1, 1'b1, 16'sd32767);
    ki_q = 16'sd32767;
    s = make_sample(16'sd0, 16'sd0, 0, 16'sd32767);
    repeat (num_sat) begin
      send_sample(s);
      release_req();
    end
    check_bit(telemetry.cmd.q == 16'sd32767, 1'b1, "q command at full scale");
    check_bit(uut.pi_q.integ == 16'sd32767, 1'b1, "q integrator at full scale");
    check_bit(ack_count == num_samples, 1'b1, $sformatf("%0d acks compared", ack_count));

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hw
+incdir+testbench
hw/foc_pkg.sv
hw/foc_sequencer.sv
hw/pwm_carrier.sv
hw/current_transform.sv
hw/pi_regulator.sv
hw/voltage_modulator.sv
hw/foc_top.sv
testbench/foc_tb.sv

// ==== Makefile ====
# Verilator build and run for the FOC current loop testbench

VERILATOR ?= verilator
TOP       ?= foc_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv testbench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
